// ==== Makefile ====
TOOL       ?= verilator
FLAGS      ?= --binary --timing --assert
LINT_FLAGS ?= --lint-only --timing
TOP        ?= id_stage_tb
FILELIST   ?= la32r_id.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
PASS_TEXT  := Everything OK

.PHONY: lint sim clean

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== hw/id_branch_unit.sv ====
module id_branch_unit (
    input  logic [la32r_id_pkg::INST_W-1:0] inst_i,
    input  logic [la32r_id_pkg::REG_W-1:0]  pc_i,
    input  la32r_id_pkg::id_ctrl_t          ctrl_i,
    input  logic [la32r_id_pkg::REG_W-1:0]  rj_data_i,
    input  logic [la32r_id_pkg::REG_W-1:0]  rk_data_i,
    input  logic                            fire_i,
    output logic                            jbr_valid_o,
    output logic [la32r_id_pkg::REG_W-1:0]  jbr_target_o
);

    logic                           eq;
    logic                           lt_s;
    logic                           lt_u;
    logic                           taken;
    logic [la32r_id_pkg::REG_W-1:0] off16;
    logic [la32r_id_pkg::REG_W-1:0] off26;

    // rk data holds rd for conditional branches
    assign eq   = (rj_data_i == rk_data_i);
    assign lt_s = ($signed(rj_data_i) < $signed(rk_data_i));
    assign lt_u = (rj_data_i < rk_data_i);

    // word offsets, sign-extended
    assign off16 = {{14{inst_i[25]}}, inst_i[25:10], 2'b00};
    // i26 is split, high part in [9:0]
    assign off26 = {{4{inst_i[9]}}, inst_i[9:0], inst_i[25:10], 2'b00};

    always_comb begin
        case (ctrl_i.br_kind)
            la32r_id_pkg::BR_JIRL,
            la32r_id_pkg::BR_B,
            la32r_id_pkg::BR_BL:   taken = 1'b1;
            la32r_id_pkg::BR_BEQ:  taken = eq;
            la32r_id_pkg::BR_BNE:  taken = !eq;
            la32r_id_pkg::BR_BLT:  taken = lt_s;
            la32r_id_pkg::BR_BGE:  taken = !lt_s;
            la32r_id_pkg::BR_BLTU: taken = lt_u;
            la32r_id_pkg::BR_BGEU: taken = !lt_u;
            default:               taken = 1'b0;
        endcase
        case (ctrl_i.br_kind)
            la32r_id_pkg::BR_JIRL:             jbr_target_o = rj_data_i + off16;
            la32r_id_pkg::BR_B, la32r_id_pkg::BR_BL: jbr_target_o = pc_i + off26;
            default:                           jbr_target_o = pc_i + off16;
        endcase
    end

    // only redirect on the accepting edge
    assign jbr_valid_o = taken && fire_i;

endmodule

// ==== hw/id_hazard_check.sv ====
module id_hazard_check (
    input  la32r_id_pkg::id_ctrl_t              ctrl_i,
    input  logic [la32r_id_pkg::REG_ADDR_W-1:0] rj_addr_i,
    input  logic [la32r_id_pkg::REG_ADDR_W-1:0] rk_addr_i,
    input  logic [la32r_id_pkg::REG_ADDR_W-1:0] ex_dest_i,
    input  logic [la32r_id_pkg::REG_ADDR_W-1:0] mem_dest_i,
    input  logic [la32r_id_pkg::REG_ADDR_W-1:0] wb_dest_i,
    output logic                                stall_o
);

    logic rj_hit;
    logic rk_hit;

    // r0 never conflicts, dest zero means no write
    assign rj_hit = ctrl_i.uses_rj && (rj_addr_i != '0)
                 && ((rj_addr_i == ex_dest_i) || (rj_addr_i == mem_dest_i)
                     || (rj_addr_i == wb_dest_i));

    // unused rk field of immediate forms is ignored
    assign rk_hit = ctrl_i.uses_rk && (rk_addr_i != '0)
                 && ((rk_addr_i == ex_dest_i) || (rk_addr_i == mem_dest_i)
                     || (rk_addr_i == wb_dest_i));

    assign stall_o = rj_hit || rk_hit;

endmodule

// ==== hw/id_opcode_decoder.sv ====
module id_opcode_decoder (
    input  logic [la32r_id_pkg::INST_W-1:0] inst_i,
    output la32r_id_pkg::id_ctrl_t          ctrl_o
);

    // format-specific opcode slices
    logic [16:0] op17;
    logic [9:0]  op10;
    logic [6:0]  op7;
    logic [5:0]  op6;

    // 3r class hit and its alu op
    logic                  hit_3r;
    logic                  hit_shift_imm;
    la32r_id_pkg::alu_op_e alu_3r;

    assign op17 = inst_i[31:15];
    assign op10 = inst_i[31:22];
    assign op7  = inst_i[31:25];
    assign op6  = inst_i[31:26];

    // reg-reg and shift-imm share the 17-bit field
    always_comb begin
        hit_3r        = 1'b1;
        hit_shift_imm = 1'b0;
        alu_3r        = la32r_id_pkg::ALU_ADD;
        case (op17)
            la32r_id_pkg::OP3R_ADD_W:  alu_3r = la32r_id_pkg::ALU_ADD;
            la32r_id_pkg::OP3R_SUB_W:  alu_3r = la32r_id_pkg::ALU_SUB;
            la32r_id_pkg::OP3R_SLT:    alu_3r = la32r_id_pkg::ALU_SLT;
            la32r_id_pkg::OP3R_SLTU:   alu_3r = la32r_id_pkg::ALU_SLTU;
            la32r_id_pkg::OP3R_NOR:    alu_3r = la32r_id_pkg::ALU_NOR;
            la32r_id_pkg::OP3R_AND:    alu_3r = la32r_id_pkg::ALU_AND;
            la32r_id_pkg::OP3R_OR:     alu_3r = la32r_id_pkg::ALU_OR;
            la32r_id_pkg::OP3R_XOR:    alu_3r = la32r_id_pkg::ALU_XOR;
            la32r_id_pkg::OP3R_SLL_W:  alu_3r = la32r_id_pkg::ALU_SLL;
            la32r_id_pkg::OP3R_SRL_W:  alu_3r = la32r_id_pkg::ALU_SRL;
            la32r_id_pkg::OP3R_SRA_W:  alu_3r = la32r_id_pkg::ALU_SRA;
            la32r_id_pkg::OP3R_SLLI_W: begin
                alu_3r        = la32r_id_pkg::ALU_SLL;
                hit_shift_imm = 1'b1;
            end
            la32r_id_pkg::OP3R_SRLI_W: begin
                alu_3r        = la32r_id_pkg::ALU_SRL;
                hit_shift_imm = 1'b1;
            end
            la32r_id_pkg::OP3R_SRAI_W: begin
                alu_3r        = la32r_id_pkg::ALU_SRA;
                hit_shift_imm = 1'b1;
            end
            default: hit_3r = 1'b0;
        endcase
    end

    always_comb begin
        // unknown encoding stays a bubble
        ctrl_o = '0;
        ctrl_o.alu_op   = la32r_id_pkg::ALU_ADD;
        ctrl_o.imm_kind = la32r_id_pkg::IMM_NONE;
        ctrl_o.br_kind  = la32r_id_pkg::BR_NONE;
        if (hit_3r) begin
            ctrl_o.alu_op  = alu_3r;
            ctrl_o.uses_rj = 1'b1;
            // shift amount is ui5, low bits of the zero-extended i12 slice
            ctrl_o.uses_rk  = !hit_shift_imm;
            ctrl_o.imm_kind = hit_shift_imm ? la32r_id_pkg::IMM_ZERO12 : la32r_id_pkg::IMM_NONE;
            ctrl_o.wb_we    = 1'b1;
        end
        // immediate alu ops, logic ones zero-extend
        case (op10)
            la32r_id_pkg::OP2RI12_SLTI,
            la32r_id_pkg::OP2RI12_SLTUI,
            la32r_id_pkg::OP2RI12_ADDI_W: begin
                ctrl_o.alu_op   = (op10 == la32r_id_pkg::OP2RI12_SLTI)  ? la32r_id_pkg::ALU_SLT :
                                  (op10 == la32r_id_pkg::OP2RI12_SLTUI) ? la32r_id_pkg::ALU_SLTU :
                                                                          la32r_id_pkg::ALU_ADD;
                ctrl_o.imm_kind = la32r_id_pkg::IMM_SIGN12;
                ctrl_o.uses_rj  = 1'b1;
                ctrl_o.wb_we    = 1'b1;
            end
            la32r_id_pkg::OP2RI12_ANDI,
            la32r_id_pkg::OP2RI12_ORI,
            la32r_id_pkg::OP2RI12_XORI: begin
                ctrl_o.alu_op   = (op10 == la32r_id_pkg::OP2RI12_ANDI) ? la32r_id_pkg::ALU_AND :
                                  (op10 == la32r_id_pkg::OP2RI12_ORI)  ? la32r_id_pkg::ALU_OR :
                                                                         la32r_id_pkg::ALU_XOR;
                ctrl_o.imm_kind = la32r_id_pkg::IMM_ZERO12;
                ctrl_o.uses_rj  = 1'b1;
                ctrl_o.wb_we    = 1'b1;
            end
            default: ;
        endcase
        // upper immediates, pcaddu12i adds to pc
        if (op7 == la32r_id_pkg::OP1RSI20_LU12I_W || op7 == la32r_id_pkg::OP1RSI20_PCADDU12I) begin
            ctrl_o.src1_pc  = (op7 == la32r_id_pkg::OP1RSI20_PCADDU12I);
            ctrl_o.alu_op   = ctrl_o.src1_pc ? la32r_id_pkg::ALU_ADD : la32r_id_pkg::ALU_LUI;
            ctrl_o.imm_kind = la32r_id_pkg::IMM_HI20;
            ctrl_o.wb_we    = 1'b1;
        end
        case (op6)
            la32r_id_pkg::OP6_JIRL: begin
                ctrl_o.br_kind  = la32r_id_pkg::BR_JIRL;
                ctrl_o.imm_kind = la32r_id_pkg::IMM_LINK;
                ctrl_o.uses_rj  = 1'b1;
                ctrl_o.src1_pc  = 1'b1;
                ctrl_o.wb_we    = 1'b1;
            end
            la32r_id_pkg::OP6_B:  ctrl_o.br_kind = la32r_id_pkg::BR_B;
            la32r_id_pkg::OP6_BL: begin
                ctrl_o.br_kind    = la32r_id_pkg::BR_BL;
                ctrl_o.imm_kind   = la32r_id_pkg::IMM_LINK;
                ctrl_o.src1_pc    = 1'b1;
                ctrl_o.wb_we      = 1'b1;
                ctrl_o.wb_link_r1 = 1'b1;
            end
            la32r_id_pkg::OP6_BEQ, la32r_id_pkg::OP6_BNE, la32r_id_pkg::OP6_BLT,
            la32r_id_pkg::OP6_BGE, la32r_id_pkg::OP6_BLTU, la32r_id_pkg::OP6_BGEU: begin
                // beq..bgeu sit in order after bl
                ctrl_o.br_kind    = la32r_id_pkg::br_kind_e'(op6 - la32r_id_pkg::OP6_BEQ
                                                             + 6'(la32r_id_pkg::BR_BEQ));
                ctrl_o.uses_rj    = 1'b1;
                ctrl_o.uses_rk    = 1'b1;
                ctrl_o.rk_from_rd = 1'b1;
            end
            default: ;
        endcase
    end

endmodule

// ==== hw/id_operand_select.sv ====
module id_operand_select (
    input  logic [la32r_id_pkg::INST_W-1:0]     inst_i,
    input  logic [la32r_id_pkg::REG_W-1:0]      pc_i,
    input  la32r_id_pkg::id_ctrl_t              ctrl_i,
    input  logic [la32r_id_pkg::REG_W-1:0]      rj_data_i,
    input  logic [la32r_id_pkg::REG_W-1:0]      rk_data_i,
    output logic [la32r_id_pkg::REG_ADDR_W-1:0] rj_addr_o,
    output logic [la32r_id_pkg::REG_ADDR_W-1:0] rk_addr_o,
    output la32r_id_pkg::id_ex_bus_t            ex_bus_o
);

    logic [11:0] imm12;
    logic [19:0] imm20;
    logic [4:0]  rd;

    assign imm12 = inst_i[21:10];
    assign imm20 = inst_i[24:5];
    assign rd    = inst_i[4:0];

    // rk: [14:10], rj: [9:5], rd: [4:0]
    assign rj_addr_o = inst_i[9:5];
    // conditional branches compare rj against rd
    assign rk_addr_o = ctrl_i.rk_from_rd ? rd : inst_i[14:10];

    always_comb begin
        ex_bus_o.alu_op = ctrl_i.alu_op;
        ex_bus_o.pc     = pc_i;
        // links and pcaddu12i start from pc
        ex_bus_o.src1   = ctrl_i.src1_pc ? pc_i : rj_data_i;
        case (ctrl_i.imm_kind)
            la32r_id_pkg::IMM_LINK:   ex_bus_o.src2 = la32r_id_pkg::LINK_OFFSET;
            la32r_id_pkg::IMM_ZERO12: ex_bus_o.src2 = {20'd0, imm12};
            la32r_id_pkg::IMM_SIGN12: ex_bus_o.src2 = {{20{imm12[11]}}, imm12};
            la32r_id_pkg::IMM_HI20:   ex_bus_o.src2 = {imm20, 12'd0};
            default:                  ex_bus_o.src2 = rk_data_i;
        endcase
        // no write means address zero
        ex_bus_o.wb_we = ctrl_i.wb_we;
        if (!ctrl_i.wb_we) begin
            ex_bus_o.wb_addr = '0;
        end else if (ctrl_i.wb_link_r1) begin
            ex_bus_o.wb_addr = la32r_id_pkg::LINK_REG;
        end else begin
            ex_bus_o.wb_addr = rd;
        end
    end

endmodule

// ==== hw/id_stage.sv ====
module id_stage (
    input  logic                                clk,
    input  logic                                rst_n_i,
    // fetch side
    input  logic                                if_valid_i,
    input  la32r_id_pkg::if_id_bus_t            if_bus_i,
    output logic                                if_ready_o,
    // register file ports
    output logic [la32r_id_pkg::REG_ADDR_W-1:0] rj_addr_o,
    output logic [la32r_id_pkg::REG_ADDR_W-1:0] rk_addr_o,
    input  logic [la32r_id_pkg::REG_W-1:0]      rj_data_i,
    input  logic [la32r_id_pkg::REG_W-1:0]      rk_data_i,
    // in-flight destinations, zero is no write
    input  logic [la32r_id_pkg::REG_ADDR_W-1:0] ex_dest_i,
    input  logic [la32r_id_pkg::REG_ADDR_W-1:0] mem_dest_i,
    input  logic [la32r_id_pkg::REG_ADDR_W-1:0] wb_dest_i,
    // redirect to fetch
    output logic                                jbr_valid_o,
    output logic [la32r_id_pkg::REG_W-1:0]      jbr_target_o,
    // execute side
    output logic                                ex_valid_o,
    output la32r_id_pkg::id_ex_bus_t            ex_bus_o,
    input  logic                                ex_ready_i
);

    la32r_id_pkg::id_ctrl_t   ctrl;
    la32r_id_pkg::id_ex_bus_t dec_bus;
    logic                     stall;
    logic                     reg_ready;
    logic                     fire;

    id_opcode_decoder u_dec (
        .inst_i (if_bus_i.inst),
        .ctrl_o (ctrl)
    );

    id_operand_select u_opsel (
        .inst_i    (if_bus_i.inst),
        .pc_i      (if_bus_i.pc),
        .ctrl_i    (ctrl),
        .rj_data_i (rj_data_i),
        .rk_data_i (rk_data_i),
        .rj_addr_o (rj_addr_o),
        .rk_addr_o (rk_addr_o),
        .ex_bus_o  (dec_bus)
    );

    id_branch_unit u_br (
        .inst_i       (if_bus_i.inst),
        .pc_i         (if_bus_i.pc),
        .ctrl_i       (ctrl),
        .rj_data_i    (rj_data_i),
        .rk_data_i    (rk_data_i),
        .fire_i       (fire),
        .jbr_valid_o  (jbr_valid_o),
        .jbr_target_o (jbr_target_o)
    );

    id_hazard_check u_haz (
        .ctrl_i     (ctrl),
        .rj_addr_i  (rj_addr_o),
        .rk_addr_i  (rk_addr_o),
        .ex_dest_i  (ex_dest_i),
        .mem_dest_i (mem_dest_i),
        .wb_dest_i  (wb_dest_i),
        .stall_o    (stall)
    );

    // held instruction waits while a source is in flight
    assign if_ready_o = reg_ready && !stall;
    assign fire       = if_valid_i && if_ready_o;

    id_stage_reg u_out (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .in_valid_i (if_valid_i && !stall),
        .in_bus_i   (dec_bus),
        .in_ready_o (reg_ready),
        .ex_valid_o (ex_valid_o),
        .ex_bus_o   (ex_bus_o),
        .ex_ready_i (ex_ready_i)
    );

endmodule

// ==== hw/id_stage_reg.sv ====
module id_stage_reg (
    input  logic                     clk,
    input  logic                     rst_n_i,
    input  logic                     in_valid_i,
    input  la32r_id_pkg::id_ex_bus_t in_bus_i,
    output logic                     in_ready_o,
    output logic                     ex_valid_o,
    output la32r_id_pkg::id_ex_bus_t ex_bus_o,
    input  logic                     ex_ready_i
);

    logic                     valid_q;
    la32r_id_pkg::id_ex_bus_t bus_q;

    // room when empty or draining this cycle
    assign in_ready_o = !valid_q || ex_ready_i;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_q <= 1'b0;
        end else if (in_valid_i && in_ready_o) begin
            valid_q <= 1'b1;
        end else if (ex_ready_i) begin
            // taken by execute, nothing new
            valid_q <= 1'b0;
        end
    end

    // payload only moves on the input handshake
    always_ff @(posedge clk) begin
        if (in_valid_i && in_ready_o) begin
            bus_q <= in_bus_i;
        end
    end

    assign ex_valid_o = valid_q;
    assign ex_bus_o   = bus_q;

endmodule

// ==== hw/la32r_id_pkg.sv ====
package la32r_id_pkg;

    // datapath and register file widths
    localparam int REG_W      = 32;
    localparam int REG_ADDR_W = 5;
    localparam int INST_W     = 32;

    // 3r format, opcode in inst[31:15]
    localparam logic [16:0] OP3R_ADD_W  = 17'h00020;
    localparam logic [16:0] OP3R_SUB_W  = 17'h00022;
    localparam logic [16:0] OP3R_SLT    = 17'h00024;
    localparam logic [16:0] OP3R_SLTU   = 17'h00025;
    localparam logic [16:0] OP3R_NOR    = 17'h00028;
    localparam logic [16:0] OP3R_AND    = 17'h00029;
    localparam logic [16:0] OP3R_OR     = 17'h0002a;
    localparam logic [16:0] OP3R_XOR    = 17'h0002b;
    localparam logic [16:0] OP3R_SLL_W  = 17'h0002e;
    localparam logic [16:0] OP3R_SRL_W  = 17'h0002f;
    localparam logic [16:0] OP3R_SRA_W  = 17'h00030;
    // shift by ui5, which sits in the rk field
    localparam logic [16:0] OP3R_SLLI_W = 17'h00081;
    localparam logic [16:0] OP3R_SRLI_W = 17'h00089;
    localparam logic [16:0] OP3R_SRAI_W = 17'h00091;

    // 2ri12 format, opcode in inst[31:22]
    localparam logic [9:0] OP2RI12_SLTI   = 10'h008;
    localparam logic [9:0] OP2RI12_SLTUI  = 10'h009;
    localparam logic [9:0] OP2RI12_ADDI_W = 10'h00a;
    localparam logic [9:0] OP2RI12_ANDI   = 10'h00d;
    localparam logic [9:0] OP2RI12_ORI    = 10'h00e;
    localparam logic [9:0] OP2RI12_XORI   = 10'h00f;

    // 1rsi20 format, opcode in inst[31:25]
    localparam logic [6:0] OP1RSI20_LU12I_W   = 7'h0a;
    localparam logic [6:0] OP1RSI20_PCADDU12I = 7'h0e;

    // 2ri16 / i26 format, opcode in inst[31:26]
    localparam logic [5:0] OP6_JIRL = 6'h13;
    localparam logic [5:0] OP6_B    = 6'h14;
    localparam logic [5:0] OP6_BL   = 6'h15;
    localparam logic [5:0] OP6_BEQ  = 6'h16;
    localparam logic [5:0] OP6_BNE  = 6'h17;
    localparam logic [5:0] OP6_BLT  = 6'h18;
    localparam logic [5:0] OP6_BGE  = 6'h19;
    localparam logic [5:0] OP6_BLTU = 6'h1a;
    localparam logic [5:0] OP6_BGEU = 6'h1b;

    // bl writes r1, link value is pc + 4
    localparam logic [REG_ADDR_W-1:0] LINK_REG    = 5'd1;
    localparam logic [REG_W-1:0]      LINK_OFFSET = 32'd4;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU, ALU_AND, ALU_NOR,
        ALU_OR, ALU_XOR, ALU_SLL, ALU_SRL, ALU_SRA, ALU_LUI
    } alu_op_e;

    typedef enum logic [2:0] {
        IMM_NONE, IMM_ZERO12, IMM_SIGN12, IMM_HI20, IMM_LINK
    } imm_kind_e;

    typedef enum logic [3:0] {
        BR_NONE, BR_JIRL, BR_B, BR_BL, BR_BEQ, BR_BNE, BR_BLT, BR_BGE, BR_BLTU, BR_BGEU
    } br_kind_e;

    typedef struct packed {
        logic [REG_W-1:0]  pc;
        logic [INST_W-1:0] inst;
    } if_id_bus_t;

    typedef struct packed {
        alu_op_e   alu_op;
        imm_kind_e imm_kind;
        br_kind_e  br_kind;
        logic      uses_rj;
        logic      uses_rk;
        logic      rk_from_rd;
        logic      src1_pc;
        logic      wb_we;
        logic      wb_link_r1;
    } id_ctrl_t;

    typedef struct packed {
        alu_op_e               alu_op;
        logic [REG_W-1:0]      src1;
        logic [REG_W-1:0]      src2;
        logic [REG_ADDR_W-1:0] wb_addr;
        logic                  wb_we;
        logic [REG_W-1:0]      pc;
    } id_ex_bus_t;

endpackage

// ==== la32r_id.f ====
hw/la32r_id_pkg.sv
hw/id_opcode_decoder.sv
hw/id_operand_select.sv
hw/id_branch_unit.sv
hw/id_hazard_check.sv
hw/id_stage_reg.sv
hw/id_stage.sv
sim/id_stage_properties.sv
sim/id_stage_tb.sv

// ==== sim/id_stage_properties.sv ====
module id_stage_properties (
    input logic                     clk,
    input logic                     rst_n_i,
    input logic                     if_valid_i,
    input logic                     if_ready_o,
    input logic                     jbr_valid_o,
    input logic                     ex_valid_o,
    input la32r_id_pkg::id_ex_bus_t ex_bus_o,
    input logic                     ex_ready_i
);

    timeunit 1ns;
    timeprecision 1ps;

    // held item may not change until execute takes it
    hold_under_backpressure: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        ex_valid_o && !ex_ready_i |=> ex_valid_o && $stable(ex_bus_o)
    ) else $error("ex bundle changed while execute stalled");

    // redirect only in an accepting cycle
    redirect_on_accept: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        jbr_valid_o |-> if_valid_i && if_ready_o
    ) else $error("redirect without fetch handshake");

    // output slot empty in reset
    empty_in_reset: assert property (
        @(posedge clk) !rst_n_i |-> !ex_valid_o
    ) else $error("ex_valid_o high during reset");

endmodule

bind id_stage id_stage_properties u_props (.*);

// ==== sim/id_stage_tb.sv ====
module id_stage_tb;

    timeunit 1ns;
    timeprecision 1ps;

    typedef struct packed {
        logic [31:0]              inst;
        logic [31:0]              pc;
        logic [31:0]              rj_d;
        logic [31:0]              rk_d;
        logic [4:0]               ex_d;
        logic [4:0]               mem_d;
        logic [4:0]               wb_d;
        logic                     ready;
        logic                     jbr;
        logic [31:0]              tgt;
        la32r_id_pkg::id_ex_bus_t bus;
    } row_t;

    logic                     clk;
    logic                     rst_n_i;
    logic                     if_valid_i;
    la32r_id_pkg::if_id_bus_t if_bus_i;
    logic                     if_ready_o;
    logic [4:0]               rj_addr_o;
    logic [4:0]               rk_addr_o;
    logic [31:0]              rj_data_i;
    logic [31:0]              rk_data_i;
    logic [4:0]               ex_dest_i;
    logic [4:0]               mem_dest_i;
    logic [4:0]               wb_dest_i;
    logic                     jbr_valid_o;
    logic [31:0]              jbr_target_o;
    logic                     ex_valid_o;
    la32r_id_pkg::id_ex_bus_t ex_bus_o;
    logic                     ex_ready_i;

    row_t                     rows[$];
    la32r_id_pkg::id_ex_bus_t exp_q[$];
    logic [31:0]              p;
    bit                       built;
    int                       bus_errs;
    int                       jbr_errs;
    int                       ready_errs;
    int                       addr_errs;
    int                       other_errs;

    id_stage dut0 (.*);

    always #2 clk = ~clk;

    // field layouts of the four formats
    function automatic logic [31:0] enc_3r(logic [16:0] op, logic [4:0] rk, rj, rd);
        return {op, rk, rj, rd};
    endfunction

    function automatic logic [31:0] enc_2ri12(logic [9:0] op, logic [11:0] imm,
                                              logic [4:0] rj, rd);
        return {op, imm, rj, rd};
    endfunction

    function automatic logic [31:0] enc_1rsi20(logic [6:0] op, logic [19:0] imm, logic [4:0] rd);
        return {op, imm, rd};
    endfunction

    function automatic logic [31:0] enc_2ri16(logic [5:0] op, logic [15:0] off,
                                              logic [4:0] rj, rd);
        return {op, off, rj, rd};
    endfunction

    // i26 keeps its high ten bits at the bottom
    function automatic logic [31:0] enc_i26(logic [5:0] op, logic [25:0] off);
        return {op, off[15:0], off[25:16]};
    endfunction

    // conditional branches read rd as their second source
    function automatic logic [4:0] expected_rk_addr(logic [31:0] inst);
        case (inst[31:26])
            la32r_id_pkg::OP6_BEQ, la32r_id_pkg::OP6_BNE, la32r_id_pkg::OP6_BLT,
            la32r_id_pkg::OP6_BGE, la32r_id_pkg::OP6_BLTU, la32r_id_pkg::OP6_BGEU:
                return inst[4:0];
            default:
                return inst[14:10];
        endcase
    endfunction

    function automatic la32r_id_pkg::id_ex_bus_t make_bus(la32r_id_pkg::alu_op_e op,
            logic [31:0] src1, src2, logic [4:0] wb_addr, logic wb_we, logic [31:0] pc);
        la32r_id_pkg::id_ex_bus_t b;
        b.alu_op  = op;
        b.src1    = src1;
        b.src2    = src2;
        b.wb_addr = wb_addr;
        b.wb_we   = wb_we;
        b.pc      = pc;
        return b;
    endfunction

    task automatic add_row(input logic [31:0] inst, rj_d, rk_d, input logic [4:0] ex_d,
            mem_d, wb_d, input logic ready, jbr, input logic [31:0] tgt,
            input la32r_id_pkg::id_ex_bus_t bus);
        row_t r;
        r = '{inst, p, rj_d, rk_d, ex_d, mem_d, wb_d, ready, jbr, tgt, bus};
        rows.push_back(r);
        p = p + 32'd4;
    endtask

    // conditional branch, word offset -4, writes nothing
    task automatic add_cond(input logic [5:0] op, input logic [31:0] rj_d, rk_d,
                            input logic taken);
        add_row(enc_2ri16(op, 16'hfffc, 5'd4, 5'd5), rj_d, rk_d, 0, 0, 0, 1'b1, taken,
                p - 32'd16, make_bus(la32r_id_pkg::ALU_ADD, rj_d, rk_d, 5'd0, 1'b0, p));
    endtask

    task automatic build_table();
        logic [31:0] inst;
        p = 32'h1c00_0100;
        // register-register alu ops
        add_row(enc_3r(la32r_id_pkg::OP3R_ADD_W, 3, 2, 4), 10, 20, 0, 0, 0, 1, 0, 0,
                make_bus(la32r_id_pkg::ALU_ADD, 10, 20, 4, 1, p));
        add_row(enc_3r(la32r_id_pkg::OP3R_SUB_W, 6, 5, 7), 32'h8000_0000, 1, 0, 0, 0, 1, 0, 0,
                make_bus(la32r_id_pkg::ALU_SUB, 32'h8000_0000, 1, 7, 1, p));
        add_row(enc_3r(la32r_id_pkg::OP3R_SLTU, 9, 8, 10), 3, 4, 0, 0, 0, 1, 0, 0,
                make_bus(la32r_id_pkg::ALU_SLTU, 3, 4, 10, 1, p));
        add_row(enc_3r(la32r_id_pkg::OP3R_NOR, 12, 11, 13), 32'hf0f0, 32'h0ff0, 0, 0, 0, 1, 0, 0,
                make_bus(la32r_id_pkg::ALU_NOR, 32'hf0f0, 32'h0ff0, 13, 1, p));
        add_row(enc_3r(la32r_id_pkg::OP3R_SRA_W, 15, 14, 16), 32'h8000_0010, 3, 0, 0, 0, 1, 0, 0,
                make_bus(la32r_id_pkg::ALU_SRA, 32'h8000_0010, 3, 16, 1, p));
        // shift amount in the rk field, ex dest on it must not stall
        // i12 slice is opcode tail 7'h01 above ui5 = 5
        inst = enc_3r(la32r_id_pkg::OP3R_SLLI_W, 5, 2, 17);
        add_row(inst, 32'h77, 32'h99, 5, 0, 0, 1, 0, 0,
                make_bus(la32r_id_pkg::ALU_SLL, 32'h77, 32'h0000_0025, 17, 1, p));
        // immediates
        add_row(enc_2ri12(la32r_id_pkg::OP2RI12_ADDI_W, 12'hffd, 3, 18), 100, 0, 0, 0, 0, 1, 0, 0,
                make_bus(la32r_id_pkg::ALU_ADD, 100, 32'hffff_fffd, 18, 1, p));
        add_row(enc_2ri12(la32r_id_pkg::OP2RI12_SLTI, 12'h7ff, 3, 18), 5, 0, 0, 0, 0, 1, 0, 0,
                make_bus(la32r_id_pkg::ALU_SLT, 5, 32'h0000_07ff, 18, 1, p));
        add_row(enc_2ri12(la32r_id_pkg::OP2RI12_SLTUI, 12'h800, 3, 18), 5, 0, 0, 0, 0, 1, 0, 0,
                make_bus(la32r_id_pkg::ALU_SLTU, 5, 32'hffff_f800, 18, 1, p));
        add_row(enc_2ri12(la32r_id_pkg::OP2RI12_ANDI, 12'hfff, 3, 18), 6, 0, 0, 0, 0, 1, 0, 0,
                make_bus(la32r_id_pkg::ALU_AND, 6, 32'h0000_0fff, 18, 1, p));
        add_row(enc_2ri12(la32r_id_pkg::OP2RI12_ORI, 12'h8a5, 3, 18), 6, 0, 0, 0, 0, 1, 0, 0,
                make_bus(la32r_id_pkg::ALU_OR, 6, 32'h0000_08a5, 18, 1, p));
        add_row(enc_2ri12(la32r_id_pkg::OP2RI12_XORI, 12'h923, 3, 18), 6, 0, 0, 0, 0, 1, 0, 0,
                make_bus(la32r_id_pkg::ALU_XOR, 6, 32'h0000_0923, 18, 1, p));
        // upper immediates
        add_row(enc_1rsi20(la32r_id_pkg::OP1RSI20_LU12I_W, 20'habcde, 19), 32'h55, 0,
                0, 0, 0, 1, 0, 0,
                make_bus(la32r_id_pkg::ALU_LUI, 32'h55, 32'habcd_e000, 19, 1, p));
        add_row(enc_1rsi20(la32r_id_pkg::OP1RSI20_PCADDU12I, 20'h00012, 20), 0, 0,
                0, 0, 0, 1, 0, 0,
                make_bus(la32r_id_pkg::ALU_ADD, p, 32'h0001_2000, 20, 1, p));
        // each condition taken, then not taken
        add_cond(la32r_id_pkg::OP6_BEQ, 5, 5, 1);
        add_cond(la32r_id_pkg::OP6_BEQ, 5, 6, 0);
        add_cond(la32r_id_pkg::OP6_BNE, 5, 6, 1);
        add_cond(la32r_id_pkg::OP6_BNE, 5, 5, 0);
        add_cond(la32r_id_pkg::OP6_BLT, 32'hffff_ffff, 1, 1);
        add_cond(la32r_id_pkg::OP6_BLT, 1, 32'hffff_ffff, 0);
        add_cond(la32r_id_pkg::OP6_BGE, 1, 32'hffff_ffff, 1);
        add_cond(la32r_id_pkg::OP6_BGE, 32'hffff_ffff, 1, 0);
        add_cond(la32r_id_pkg::OP6_BLTU, 1, 32'hffff_ffff, 1);
        add_cond(la32r_id_pkg::OP6_BLTU, 32'hffff_ffff, 1, 0);
        add_cond(la32r_id_pkg::OP6_BGEU, 32'hffff_ffff, 1, 1);
        add_cond(la32r_id_pkg::OP6_BGEU, 1, 32'hffff_ffff, 0);
        // unconditional jumps
        add_row(enc_i26(la32r_id_pkg::OP6_B, 26'h000_0100), 8, 9, 0, 0, 0, 1, 1, p + 32'h400,
                make_bus(la32r_id_pkg::ALU_ADD, 8, 9, 0, 0, p));
        add_row(enc_i26(la32r_id_pkg::OP6_BL, 26'h3ff_fffc), 8, 9, 0, 0, 0, 1, 1, p - 32'd16,
                make_bus(la32r_id_pkg::ALU_ADD, p, 4, 1, 1, p));
        add_row(enc_2ri16(la32r_id_pkg::OP6_JIRL, 16'h0010, 6, 21), 32'h1c00_2000, 0,
                0, 0, 0, 1, 1, 32'h1c00_2040,
                make_bus(la32r_id_pkg::ALU_ADD, p, 4, 21, 1, p));
        // raw hazards against ex, mem, wb and the rd compare source
        add_row(enc_3r(la32r_id_pkg::OP3R_ADD_W, 3, 2, 4), 1, 1, 2, 0, 0, 0, 0, 0, '0);
        add_row(enc_3r(la32r_id_pkg::OP3R_ADD_W, 3, 2, 4), 1, 1, 0, 3, 0, 0, 0, 0, '0);
        add_row(enc_3r(la32r_id_pkg::OP3R_SUB_W, 6, 7, 8), 1, 1, 0, 0, 7, 0, 0, 0, '0);
        add_row(enc_2ri16(la32r_id_pkg::OP6_BEQ, 16'h4, 4, 5), 1, 1, 5, 0, 0, 0, 0, 0, '0);
        // r0 and the imm rk field never stall
        add_row(enc_3r(la32r_id_pkg::OP3R_ADD_W, 0, 0, 4), 7, 9, 4, 4, 4, 1, 0, 0,
                make_bus(la32r_id_pkg::ALU_ADD, 7, 9, 4, 1, p));
        add_row(enc_2ri12(la32r_id_pkg::OP2RI12_ADDI_W, 12'h009, 3, 22), 40, 0, 9, 0, 0, 1, 0, 0,
                make_bus(la32r_id_pkg::ALU_ADD, 40, 9, 22, 1, p));
    endtask

    task automatic compare_bus(input la32r_id_pkg::id_ex_bus_t exp,
                               input la32r_id_pkg::id_ex_bus_t act);
        if (act !== exp) begin
            bus_errs++;
            $display("Error at %0d ns: ex bundle %h, expected %h", $time, act, exp);
        end
    endtask

    // target only matters when a redirect is expected
    task automatic compare_redirect(input logic exp_v, input logic [31:0] exp_t,
                                    input logic act_v, input logic [31:0] act_t);
        if (act_v !== exp_v || (exp_v && act_t !== exp_t)) begin
            jbr_errs++;
            $display("Error at %0d ns: redirect %b/%h, expected %b/%h",
                     $time, act_v, act_t, exp_v, exp_t);
        end
    endtask

    task automatic compare_ready(input logic exp, input logic act);
        if (act !== exp) begin
            ready_errs++;
            $display("Error at %0d ns: if_ready_o %b, expected %b", $time, act, exp);
        end
    endtask

    task automatic compare_addr(input string name,
                                input logic [la32r_id_pkg::REG_ADDR_W-1:0] exp,
                                input logic [la32r_id_pkg::REG_ADDR_W-1:0] act);
        if (act !== exp) begin
            addr_errs++;
            $display("Error at %0d ns: %s %0d, expected %0d", $time, name, act, exp);
        end
    endtask

    task automatic apply_row(input row_t r);
        @(negedge clk);
        if_valid_i = 1'b1;
        if_bus_i   = '{pc: r.pc, inst: r.inst};
        rj_data_i  = r.rj_d;
        rk_data_i  = r.rk_d;
        ex_dest_i  = r.ex_d;
        mem_dest_i = r.mem_d;
        wb_dest_i  = r.wb_d;
        #1;
        // register file read ports
        compare_addr("rj_addr_o", r.inst[9:5], rj_addr_o);
        compare_addr("rk_addr_o", expected_rk_addr(r.inst), rk_addr_o);
        if (!r.ready) begin
            // stalled row is offered once, never taken
            compare_ready(1'b0, if_ready_o);
            compare_redirect(1'b0, '0, jbr_valid_o, jbr_target_o);
        end else begin
            // slot full and not draining holds fetch
            compare_ready(exp_q.size() == 0 || ex_ready_i, if_ready_o);
            while (!if_ready_o) begin
                @(negedge clk);
                #1;
                compare_ready(exp_q.size() == 0 || ex_ready_i, if_ready_o);
            end
            compare_redirect(r.jbr, r.tgt, jbr_valid_o, jbr_target_o);
            exp_q.push_back(r.bus);
        end
    endtask

    // random gaps on the execute side
    initial begin
        void'($urandom(32'hde82_7256));
        forever begin
            @(negedge clk);
            if (rst_n_i) begin
                ex_ready_i <= ($urandom_range(3, 0) != 0);
            end
        end
    end

    // in-order scoreboard on execute transfers
    always @(posedge clk) begin
        if (rst_n_i && ex_valid_o && ex_ready_i) begin
            if (exp_q.size() == 0) begin
                other_errs++;
                $display("Execute received a bundle that was never sent, at %0d ns", $time);
            end else begin
                compare_bus(exp_q.pop_front(), ex_bus_o);
            end
        end
    end

    initial begin
        wait (built);
        #(rows.size() * 20 * 4 + 10 * 4);
        $display("Timeout: the stage stopped making progress");
        $display("Something failed");
        $finish;
    end

    initial begin
        clk        = 1'b0;
        rst_n_i    = 1'b0;
        if_valid_i = 1'b0;
        if_bus_i   = '0;
        rj_data_i  = '0;
        rk_data_i  = '0;
        ex_dest_i  = '0;
        mem_dest_i = '0;
        wb_dest_i  = '0;
        ex_ready_i = 1'b0;
        build_table();
        built = 1'b1;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst_n_i = 1'b1;
        foreach (rows[i]) begin
            apply_row(rows[i]);
        end
        @(negedge clk);
        if_valid_i = 1'b0;
        // drain what is still in flight
        while (exp_q.size() != 0) begin
            @(negedge clk);
        end
        repeat (4) @(negedge clk);
        $display("errors: bus %0d, redirect %0d, ready %0d, address %0d, other %0d",
                 bus_errs, jbr_errs, ready_errs, addr_errs, other_errs);
        if (bus_errs + jbr_errs + ready_errs + addr_errs + other_errs == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule
